// File: sources.f
logic/debug_unit_pkg.sv
logic/instr_loader.sv
logic/state_dumper.sv
logic/debug_control.sv
logic/debug_unit_top.sv
dv/uart_tx_responder.sv
dv/tb_debug_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the debug unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_debug_unit
log=sim.log

rm -rf obj_dir "$log" build.log

verilator --binary --timing -j 0 \
    --top-module "$top" \
    -f sources.f \
    -o "$top" \
    > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/"$top" > "$log" 2>&1 \
    || { echo "Simulator exited with an error, see $log"; exit 1; }

grep -q "TEST FAIL" "$log" && { echo "Simulation reported a failure, see $log"; exit 1; }
grep -q "TEST PASS" "$log" || { echo "No result found in $log"; exit 1; }
echo "Simulation passed"

// File: dv/tb_debug_unit.sv
module tb_debug_unit import debug_unit_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic [byte_w-1:0]   rx_data;
    logic                rx_done;
    logic                tx_done;
    logic                prog_end;
    cpu_snapshot_t       snapshot;
    logic                tx_start;
    logic [byte_w-1:0]   tx_data;
    logic [word_w-1:0]   instr;
    logic [word_w-1:0]   instr_addr;
    logic                instr_valid;
    logic                start;
    logic                step;
    logic                tx_busy;

    integer              seed = 32'h0970df6c;
    int                  errors = 0;
    int                  timeouts = 0;
    int                  exp_sent = 0;              // Bytes the model has accounted for
    int                  step_cycles = 0;           // Cycles with o_step high
    int                  start_cycles = 0;          // Cycles with o_tx_start high
    int                  exp_starts = 0;            // Start pulses the model has accounted for
    logic [word_w-1:0]   got_instr[$];
    logic [word_w-1:0]   got_addr[$];
    logic [word_w-1:0]   exp_instr[$];

    debug_unit_top u_dut (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_rx_data     (rx_data),
        .i_rx_done     (rx_done),
        .i_tx_done     (tx_done),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .i_prog_end    (prog_end),
        .i_snapshot    (snapshot),
        .o_instr       (instr),
        .o_instr_addr  (instr_addr),
        .o_instr_valid (instr_valid),
        .o_start       (start),
        .o_step        (step)
    );

    uart_tx_responder u_resp (
        .clk        (clk),
        .i_tx_start (tx_start),
        .i_tx_data  (tx_data),
        .o_tx_done  (tx_done),
        .o_busy     (tx_busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (instr_valid) begin
            got_instr.push_back(instr);
            got_addr.push_back(instr_addr);
        end
        if (step) begin
            step_cycles++;
        end
        if (tx_start) begin
            start_cycles++;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    function automatic cpu_snapshot_t random_snapshot();
        logic [8*word_w-1:0] bits;
        int                  i;
        for (i = 0; i < 8; i++) begin
            bits[i*word_w +: word_w] = $random(seed);
        end
        return bits[dump_bytes*byte_w-1:0];
    endfunction

    // Byte n of the snapshot counted from the least significant end
    function automatic logic [byte_w-1:0] snap_byte(input cpu_snapshot_t s, input int n);
        logic [dump_bytes*byte_w-1:0] flat;
        flat = s;
        flat = flat >> (n * byte_w);
        return flat[byte_w-1:0];
    endfunction

    function automatic logic is_command(input logic [byte_w-1:0] b);
        return (b == cmd_load) || (b == cmd_debug) || (b == cmd_run) ||
               (b == cmd_step) || (b == cmd_end_debug);
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout waiting for %s, control mode %s", what, u_dut.u_control.mode_q.name());
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic send_byte(input logic [byte_w-1:0] b);
        repeat (rand_below(3)) @(posedge clk);
        #1;
        rx_data = b;
        rx_done = 1'b1;
        @(posedge clk);
        #1;
        rx_done = 1'b0;
    endtask

    task automatic send_word(input logic [word_w-1:0] w);
        int i;
        for (i = bytes_per_word - 1; i >= 0; i--) begin
            send_byte(w[i*byte_w +: byte_w]);           // MSB first
        end
    endtask

    task automatic wait_start(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (start !== level && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (start !== level) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_step(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (step !== level && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (step !== level) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_instr_count(input int n);
        int cycles;
        cycles = 0;
        while (got_instr.size() < n && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (got_instr.size() < n) begin
            report_timeout("instruction valid pulses");
        end
    endtask

    task automatic check_dump(input cpu_snapshot_t exp_snap, input string what);
        int                cycles;
        int                i;
        logic [byte_w-1:0] exp_b;
        cycles = 0;
        while (u_resp.sent_q.size() <= exp_sent && cycles < 20) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (u_resp.sent_q.size() <= exp_sent) begin
            report_timeout({"first dump byte, ", what});
        end else begin
            snapshot = random_snapshot();               // Later bytes come from the captured copy
            cycles = 0;
            while ((u_resp.sent_q.size() < exp_sent + dump_bytes || tx_busy) &&
                   cycles < 1000) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (tx_busy) begin
                report_timeout({"end of dump, ", what});
            end
            repeat (2) @(posedge clk);                  // Done pulse and then the mode change
            #1;
            if (start_cycles - exp_starts != dump_bytes) begin
                errors++;
                $display("[FAIL] %s o_tx_start pulses: got %h expected %h", what,
                         start_cycles - exp_starts, dump_bytes);
            end
            if (u_resp.sent_q.size() != exp_sent + dump_bytes) begin
                errors++;
                $display("[FAIL] %s o_tx_data bytes: got %h expected %h", what,
                         u_resp.sent_q.size() - exp_sent, dump_bytes);
            end
            for (i = 0; i < dump_bytes && exp_sent + i < u_resp.sent_q.size(); i++) begin
                exp_b = snap_byte(exp_snap, i);
                if (u_resp.sent_q[exp_sent + i] !== exp_b) begin
                    errors++;
                    $display("[FAIL] %s o_tx_data byte %0d: got %h expected %h", what, i,
                             u_resp.sent_q[exp_sent + i], exp_b);
                end
            end
        end
        exp_sent   = u_resp.sent_q.size();
        exp_starts = start_cycles;
    endtask

    // An unknown byte must leave every output alone
    task automatic check_quiet(input string what);
        logic [byte_w-1:0] b;
        int                r;
        int                steps_before;
        int                sent_before;
        int                valid_before;
        r = $random(seed);
        b = r[7:0];
        if (is_command(b)) begin
            b = b | 8'h80;
        end
        steps_before = step_cycles;
        sent_before  = u_resp.sent_q.size();
        valid_before = got_instr.size();
        send_byte(b);
        repeat (6) @(posedge clk);
        #1;
        if (step_cycles != steps_before || u_resp.sent_q.size() != sent_before ||
            got_instr.size() != valid_before) begin
            errors++;
            $display("Unknown byte %h in %s caused a step, transmit or valid pulse", b, what);
        end
    endtask

    initial begin
        cpu_snapshot_t     snap;
        logic [word_w-1:0] w;
        logic [word_w-1:0] exp_addr;
        int                n_words;
        int                k;
        int                steps_before;

        rst_n    = 1'b0;
        rx_data  = '0;
        rx_done  = 1'b0;
        prog_end = 1'b0;
        snapshot = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("o_tx_start", tx_start, 1'b0);
        check_bit("o_instr_valid", instr_valid, 1'b0);
        check_bit("o_start", start, 1'b0);
        check_bit("o_step", step, 1'b0);
        check_quiet("idle");

        // Program loading with the halt word last
        n_words = 3 + rand_below(6);
        send_byte(cmd_load);
        for (k = 0; k < n_words; k++) begin
            w = $random(seed);
            if (w == halt_word) begin
                w = 32'h0;
            end
            exp_instr.push_back(w);
            send_word(w);
        end
        exp_instr.push_back(halt_word);
        send_word(halt_word);
        wait_instr_count(n_words + 1);
        @(posedge clk);
        #1;
        for (k = 0; k < got_instr.size() && k < exp_instr.size(); k++) begin
            exp_addr = k * addr_stride;
            if (got_instr[k] !== exp_instr[k]) begin
                errors++;
                $display("[FAIL] o_instr word %0d: got %h expected %h", k,
                         got_instr[k], exp_instr[k]);
            end
            if (got_addr[k] !== exp_addr) begin
                errors++;
                $display("[FAIL] o_instr_addr word %0d: got %h expected %h", k,
                         got_addr[k], exp_addr);
            end
        end

        // Continuous run until program end
        snap     = random_snapshot();
        snapshot = snap;
        send_byte(cmd_run);
        wait_start(1'b1, "o_start after run command");
        check_bit("o_step", step, 1'b1);
        repeat (5 + rand_below(20)) @(posedge clk);
        #1;
        prog_end = 1'b1;
        wait_step(1'b0, "o_step fall after program end");
        check_dump(snap, "run");
        prog_end = 1'b0;
        wait_start(1'b0, "o_start fall after run");
        check_bit("o_start", start, 1'b0);

        // Debug session
        snapshot = random_snapshot();
        send_byte(cmd_debug);
        wait_start(1'b1, "o_start after debug command");
        check_bit("o_step", step, 1'b0);
        for (k = 0; k < 3; k++) begin
            snap         = random_snapshot();
            snapshot     = snap;
            steps_before = step_cycles;
            send_byte(cmd_step);
            check_dump(snap, "debug step");
            if (step_cycles != steps_before + 1) begin
                errors++;
                $display("[FAIL] o_step cycles: got %h expected %h",
                         step_cycles - steps_before, 1);
            end
            check_bit("o_start", start, 1'b1);
            check_quiet("debugging");
        end
        snap     = random_snapshot();
        snapshot = snap;
        send_byte(cmd_end_debug);
        check_dump(snap, "end of debug");
        wait_start(1'b0, "o_start fall after end of debug");
        check_bit("o_start", start, 1'b0);
        check_quiet("idle after debug");

        if (got_instr.size() != n_words + 1) begin
            errors++;
            $display("[FAIL] o_instr_valid pulses: got %h expected %h",
                     got_instr.size(), n_words + 1);
        end
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: dv/uart_tx_responder.sv
module uart_tx_responder import debug_unit_pkg::*; (
    input  logic                clk,
    input  logic                i_tx_start,             // Strobe from the dumper
    input  logic [byte_w-1:0]   i_tx_data,
    output logic                o_tx_done,
    output logic                o_busy                  // A byte is on the line
);

    logic [byte_w-1:0] sent_q[$];                       // Every byte in order of transmission
    integer            seed = 32'h0970df6c;
    int                r;
    int                delay;

    initial begin
        o_tx_done = 1'b0;
        o_busy    = 1'b0;
        forever begin
            @(negedge clk);
            if (i_tx_start) begin
                sent_q.push_back(i_tx_data);
                o_busy = 1'b1;
                r      = $random(seed) & 32'h7fffffff;
                delay  = 1 + r % 8;                     // One to eight cycles on the line
                repeat (delay) begin
                    @(posedge clk);
                end
                #1;
                o_tx_done = 1'b1;
                @(posedge clk);
                #1;
                o_tx_done = 1'b0;
                o_busy    = 1'b0;
            end
        end
    end

endmodule

// File: logic/debug_unit_top.sv
module debug_unit_top import debug_unit_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,

    // UART receiver side
    input  logic [byte_w-1:0]   i_rx_data,
    input  logic                i_rx_done,              // Strobe marking a valid i_rx_data

    // UART transmitter side
    input  logic                i_tx_done,              // Strobe at the end of a byte
    output logic                o_tx_start,
    output logic [byte_w-1:0]   o_tx_data,

    // Processor side
    input  logic                i_prog_end,             // High once the program has finished
    input  cpu_snapshot_t       i_snapshot,
    output logic [word_w-1:0]   o_instr,
    output logic [word_w-1:0]   o_instr_addr,
    output logic                o_instr_valid,          // Write strobe for instruction memory
    output logic                o_start,
    output logic                o_step
);

    logic load_en;                                      // Loader owns the receive stream
    logic halt_seen;
    logic dump_req;
    logic dump_done;

    debug_control u_control (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rx_data   (i_rx_data),
        .i_rx_done   (i_rx_done),
        .i_prog_end  (i_prog_end),
        .i_halt_seen (halt_seen),
        .i_dump_done (dump_done),
        .o_load_en   (load_en),
        .o_dump_req  (dump_req),
        .o_start     (o_start),
        .o_step      (o_step)
    );

    instr_loader u_loader (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_load_en     (load_en),
        .i_rx_data     (i_rx_data),
        .i_rx_done     (i_rx_done),
        .o_instr       (o_instr),
        .o_instr_addr  (o_instr_addr),
        .o_instr_valid (o_instr_valid),
        .o_halt_seen   (halt_seen)
    );

    state_dumper u_dumper (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_dump_req  (dump_req),
        .i_snapshot  (i_snapshot),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_tx_data   (o_tx_data),
        .o_dump_done (dump_done)
    );

endmodule

// File: logic/debug_control.sv
module debug_control import debug_unit_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [byte_w-1:0]   i_rx_data,
    input  logic                i_rx_done,
    input  logic                i_prog_end,
    input  logic                i_halt_seen,            // Loader saw the halt word
    input  logic                i_dump_done,            // Last snapshot byte sent
    output logic                o_load_en,
    output logic                o_dump_req,
    output logic                o_start,
    output logic                o_step
);

    mode_t mode_q, mode_d;
    logic  ret_debug_q, ret_debug_d;                    // Dump returns to debugging
    logic  start_q, start_d;
    logic  step_q, step_d;
    logic  dump_req_q, dump_req_d;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q      <= mode_idle;
            ret_debug_q <= 1'b0;
            start_q     <= 1'b0;
            step_q      <= 1'b0;
            dump_req_q  <= 1'b0;
        end else begin
            mode_q      <= mode_d;
            ret_debug_q <= ret_debug_d;
            start_q     <= start_d;
            step_q      <= step_d;
            dump_req_q  <= dump_req_d;
        end
    end

    always_comb begin
        mode_d      = mode_q;
        ret_debug_d = ret_debug_q;
        start_d     = start_q;
        step_d      = step_q;
        dump_req_d  = 1'b0;                             // Request is a single-cycle pulse

        case (mode_q)
            mode_idle: begin
                if (i_rx_done) begin
                    case (i_rx_data)
                        cmd_load: begin
                            mode_d = mode_loading;
                        end
                        cmd_debug: begin
                            mode_d  = mode_debugging;
                            start_d = 1'b1;             // Held for the whole session
                        end
                        cmd_run: begin
                            mode_d  = mode_running;
                            start_d = 1'b1;
                            step_d  = 1'b1;             // Step every cycle
                        end
                        default: begin
                            mode_d = mode_idle;         // Unknown byte ignored
                        end
                    endcase
                end
            end

            mode_loading: begin
                if (i_halt_seen) begin
                    mode_d = mode_idle;
                end
            end

            mode_running: begin
                if (i_prog_end) begin
                    step_d      = 1'b0;
                    dump_req_d  = 1'b1;
                    ret_debug_d = 1'b0;
                    mode_d      = mode_dumping;
                end
            end

            mode_debugging: begin
                // The step pulse is out this cycle, so the dump follows now
                if (step_q) begin
                    step_d      = 1'b0;
                    dump_req_d  = 1'b1;
                    ret_debug_d = 1'b1;
                    mode_d      = mode_dumping;
                end else if (i_rx_done) begin
                    case (i_rx_data)
                        cmd_step: begin
                            step_d = 1'b1;
                        end
                        cmd_end_debug: begin
                            dump_req_d  = 1'b1;
                            ret_debug_d = 1'b0;
                            mode_d      = mode_dumping;
                        end
                        default: begin
                            mode_d = mode_debugging;    // Unknown byte ignored
                        end
                    endcase
                end
            end

            mode_dumping: begin
                if (i_dump_done) begin
                    if (ret_debug_q) begin
                        mode_d = mode_debugging;
                    end else begin
                        mode_d  = mode_idle;
                        start_d = 1'b0;                 // Run or session is over
                    end
                end
            end

            default: begin
                mode_d = mode_idle;
            end
        endcase
    end

    assign o_load_en  = (mode_q == mode_loading);
    assign o_dump_req = dump_req_q;
    assign o_start    = start_q;
    assign o_step     = step_q;

endmodule

// File: logic/state_dumper.sv
module state_dumper import debug_unit_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_dump_req,             // Pulse to capture and start sending
    input  cpu_snapshot_t       i_snapshot,
    input  logic                i_tx_done,              // Transmitter finished a byte
    output logic                o_tx_start,
    output logic [byte_w-1:0]   o_tx_data,
    output logic                o_dump_done
);

    cpu_snapshot_t snap_q;                              // Frozen copy for one dump
    dump_cnt_t     idx_q;                               // Byte being sent
    logic          busy_q;
    logic          tx_start_q;
    logic          done_q;
    logic          last_byte;

    assign last_byte = (idx_q == dump_cnt_t'(dump_bytes - 1));

    // Capture on a request only
    always_ff @(posedge clk) begin
        if (i_dump_req) begin
            snap_q <= i_snapshot;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idx_q      <= '0;
            busy_q     <= 1'b0;
            tx_start_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            done_q     <= 1'b0;
            if (i_dump_req) begin
                idx_q      <= '0;
                busy_q     <= 1'b1;
                tx_start_q <= 1'b1;                     // First byte right away
            end else if (busy_q && i_tx_done) begin
                if (last_byte) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    idx_q      <= idx_q + 1'b1;
                    tx_start_q <= 1'b1;
                end
            end
        end
    end

    // LSB of the snapshot goes out first
    assign o_tx_data   = snap_q[idx_q * byte_w +: byte_w];
    assign o_tx_start  = tx_start_q;
    assign o_dump_done = done_q;

endmodule

// File: logic/instr_loader.sv
module instr_loader import debug_unit_pkg::*; (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_load_en,              // High while in loading mode
    input  logic [byte_w-1:0]   i_rx_data,
    input  logic                i_rx_done,
    output logic [word_w-1:0]   o_instr,
    output logic [word_w-1:0]   o_instr_addr,
    output logic                o_instr_valid,
    output logic                o_halt_seen
);

    logic [word_w-1:0]                  word_q;         // Assembly register
    logic [word_w-1:0]                  addr_q;
    logic [$clog2(bytes_per_word)-1:0]  byte_cnt;
    logic                               valid_q;
    logic                               halt_q;
    logic [word_w-1:0]                  next_word;
    logic                               last_byte;

    // New byte enters at the bottom and earlier bytes move up
    assign next_word = {word_q[word_w-byte_w-1:0], i_rx_data};
    assign last_byte = (int'(byte_cnt) == bytes_per_word - 1);

    // Bytes shift in only while loading
    always_ff @(posedge clk) begin
        if (i_load_en && i_rx_done) begin
            word_q <= next_word;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt <= '0;
            valid_q  <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            halt_q  <= 1'b0;
            if (!i_load_en) begin
                byte_cnt <= '0;                         // Fresh word on every load
            end else if (i_rx_done) begin
                byte_cnt <= byte_cnt + 1'b1;            // Wraps after the fourth byte
                if (last_byte) begin
                    valid_q <= 1'b1;
                    halt_q  <= (next_word == halt_word);
                end
            end
        end
    end

    // Address of the word being presented steps after each write
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q <= '0;
        end else if (!i_load_en) begin
            addr_q <= '0;
        end else if (valid_q) begin
            addr_q <= addr_q + word_w'(addr_stride);
        end
    end

    assign o_instr       = word_q;
    assign o_instr_addr  = addr_q;
    assign o_instr_valid = valid_q;
    assign o_halt_seen   = halt_q;

endmodule

// File: logic/debug_unit_pkg.sv
package debug_unit_pkg;

    // UART and instruction geometry
    localparam int byte_w         = 8;                    // One UART character
    localparam int word_w         = 32;                   // Instruction and address width
    localparam int bytes_per_word = word_w / byte_w;      // Four bytes sent MSB first
    localparam int addr_stride    = 4;                    // Byte addressed instruction memory

    // Program loading stops on this word, which is itself written
    localparam logic [word_w-1:0] halt_word = '1;

    // One-hot host command bytes
    localparam logic [byte_w-1:0] cmd_load      = 8'h01;  // Start program loading
    localparam logic [byte_w-1:0] cmd_debug     = 8'h02;  // Enter step-by-step mode
    localparam logic [byte_w-1:0] cmd_run       = 8'h04;  // Continuous run
    localparam logic [byte_w-1:0] cmd_step      = 8'h08;  // One step in debug mode
    localparam logic [byte_w-1:0] cmd_end_debug = 8'h10;  // Final dump then back to idle

    // Pipeline latch section widths
    localparam int id_ex_w   = 144;
    localparam int ex_mem_w  = 32;
    localparam int mem_wb_w  = 40;
    localparam int control_w = 24;

    // Pipeline snapshot with the control word on top and ID/EX at the bottom
    typedef struct packed {
        logic [control_w-1:0] control;                    // Control unit outputs
        logic [mem_wb_w-1:0]  mem_wb;                     // MEM/WB latch
        logic [ex_mem_w-1:0]  ex_mem;                     // EX/MEM latch
        logic [id_ex_w-1:0]   id_ex;                      // ID/EX latch goes out first
    } cpu_snapshot_t;

    // Whole snapshot goes out as bytes
    localparam int dump_bytes = $bits(cpu_snapshot_t) / byte_w;

    // Byte index over a dump
    typedef logic [$clog2(dump_bytes + 1)-1:0] dump_cnt_t;

    // Modes of the debug unit controller
    typedef enum logic [2:0] {
        mode_idle,                                        // Waiting for a command
        mode_loading,                                     // Bytes go to the instruction loader
        mode_running,                                     // Free run until program end
        mode_debugging,                                   // Waiting for step or end-debug
        mode_dumping                                      // Snapshot going out over UART
    } mode_t;

endpackage
